//--- common/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;

	// Major opcodes, RV32I base set only
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_JALR = 3'b000;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;
	localparam logic [2:0] F3_B    = 3'b000; // Loads and stores
	localparam logic [2:0] F3_H    = 3'b001;
	localparam logic [2:0] F3_W    = 3'b010;
	localparam logic [2:0] F3_BU   = 3'b100;
	localparam logic [2:0] F3_HU   = 3'b101;
	localparam logic [2:0] F3_ADD  = 3'b000; // ALU ops, imm and reg forms
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

	typedef enum logic [3:0] {
		CLS_NONE, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH,
		CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP, CLS_SYSTEM
	} insn_class_e;

	typedef enum logic [5:0] {
		KIND_LUI, KIND_AUIPC, KIND_JAL, KIND_JALR,
		KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
		KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU, KIND_SB, KIND_SH, KIND_SW,
		KIND_ADDI, KIND_SLTI, KIND_SLTIU, KIND_XORI, KIND_ORI, KIND_ANDI,
		KIND_SLLI, KIND_SRLI, KIND_SRAI,
		KIND_ADD, KIND_SUB, KIND_SLL, KIND_SLT, KIND_SLTU, KIND_XOR,
		KIND_SRL, KIND_SRA, KIND_OR, KIND_AND,
		KIND_ECALL_EBREAK, KIND_ILLEGAL
	} insn_kind_e;

	typedef enum logic [1:0] {
		MS_IDLE, MS_READ, MS_WRITE, MS_PREFETCHED
	} mem_state_e;

endpackage

`default_nettype wire

//--- source/mem_port.sv
`default_nettype none

module mem_port import frontend_pkg::*; #(
	parameter bit LATCHED_MEM_RDATA = 1'b0
) (
	input  logic  clk,
	input  logic  resetn,

	input  logic  mem_do_prefetch,
	input  logic  mem_do_rinst,
	input  logic  mem_do_rdata,
	input  logic  mem_do_wdata,
	input  word_t fetch_pc,
	input  word_t data_addr,

	output logic  mem_valid,
	output logic  mem_instr,
	input  logic  mem_ready,
	output word_t mem_addr,
	input  word_t mem_rdata,

	output logic  mem_la_read,
	output logic  mem_la_write,
	output word_t mem_la_addr,

	output logic  mem_done,
	output logic  rinst_done,
	output word_t insn_word
);

	mem_state_e mem_state;
	word_t      rdata_q;
	logic       mem_xfer;
	logic       instr_req;

	assign instr_req = mem_do_prefetch || mem_do_rinst;
	assign mem_xfer  = mem_valid && mem_ready;

	assign mem_la_read  = (mem_state == MS_IDLE) && (instr_req || mem_do_rdata);
	assign mem_la_write = (mem_state == MS_IDLE) && mem_do_wdata;
	assign mem_la_addr  = instr_req ? {fetch_pc[31:2], 2'b00} : {data_addr[31:2], 2'b00};

	// Held prefetch word completes the fetch without a bus cycle
	assign mem_done = (mem_xfer && (mem_state == MS_READ || mem_state == MS_WRITE) &&
			(mem_do_rinst || mem_do_rdata || mem_do_wdata)) ||
			(mem_state == MS_PREFETCHED && mem_do_rinst);
	assign rinst_done = mem_done && mem_do_rinst;

	assign insn_word = (mem_xfer || LATCHED_MEM_RDATA) ? mem_rdata : rdata_q;

	always_ff @(posedge clk) begin
		if (mem_xfer)
			rdata_q <= mem_rdata;
		if (mem_la_read || mem_la_write) begin
			mem_addr  <= mem_la_addr;
			mem_instr <= instr_req; // Write never overlaps a fetch
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mem_state <= MS_IDLE;
			mem_valid <= 1'b0;
		end else begin
			case (mem_state)
				MS_IDLE: begin
					if (instr_req || mem_do_rdata) begin
						mem_valid <= 1'b1;
						mem_state <= MS_READ;
					end
					if (mem_do_wdata) begin
						mem_valid <= 1'b1;
						mem_state <= MS_WRITE;
					end
				end
				MS_READ: begin
					if (mem_xfer) begin
						mem_valid <= 1'b0;
						mem_state <= (mem_do_rinst || mem_do_rdata) ? MS_IDLE : MS_PREFETCHED;
					end
				end
				MS_WRITE: begin
					if (mem_xfer) begin
						mem_valid <= 1'b0;
						mem_state <= MS_IDLE;
					end
				end
				MS_PREFETCHED: begin
					if (mem_do_rinst)
						mem_state <= MS_IDLE;
				end
			endcase
		end
	end

	// Execute side issues one kind of request at a time
	a_req_excl: assert property (@(posedge clk) disable iff (!resetn)
			$onehot0({instr_req, mem_do_rdata, mem_do_wdata}));

	a_prefetch_hold: assert property (@(posedge clk) disable iff (!resetn)
			mem_state == MS_PREFETCHED |-> mem_do_prefetch && !mem_do_rdata && !mem_do_wdata);

	a_bus_stable: assert property (@(posedge clk) disable iff (!resetn)
			mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_instr));

endmodule

`default_nettype wire

//--- decoder/opcode_predecode.sv
`default_nettype none

module opcode_predecode import frontend_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        rinst_done,
	input  word_t       insn_word,
	output logic        stage1_valid,
	output insn_class_e insn_class,
	output reg_idx_t    rd,
	output reg_idx_t    rs1,
	output reg_idx_t    rs2,
	output word_t       imm_j,
	output word_t       held_word
);

	opcode_t     opcode;
	insn_class_e next_class;

	assign opcode = insn_word[6:0];

	always_comb begin
		case (opcode)
			OPC_LUI:    next_class = CLS_LUI;
			OPC_AUIPC:  next_class = CLS_AUIPC;
			OPC_JAL:    next_class = CLS_JAL;
			OPC_JALR:   next_class = (insn_word[14:12] == F3_JALR) ? CLS_JALR : CLS_NONE;
			OPC_BRANCH: next_class = CLS_BRANCH;
			OPC_LOAD:   next_class = CLS_LOAD;
			OPC_STORE:  next_class = CLS_STORE;
			OPC_OP_IMM: next_class = CLS_OP_IMM;
			OPC_OP:     next_class = CLS_OP;
			OPC_SYSTEM: next_class = CLS_SYSTEM;
			default:    next_class = CLS_NONE; // Also catches low bits != 11
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			stage1_valid <= 1'b0;
			insn_class   <= CLS_NONE;
		end else begin
			stage1_valid <= rinst_done;
			if (rinst_done)
				insn_class <= next_class;
		end
	end

	always_ff @(posedge clk) begin
		if (rinst_done) begin
			rd        <= insn_word[11:7];
			rs1       <= insn_word[19:15];
			rs2       <= insn_word[24:20];
			held_word <= insn_word;
			// J-type bits scattered as imm[20|10:1|11|19:12]
			imm_j <= {{11{insn_word[31]}}, insn_word[31], insn_word[19:12],
					insn_word[20], insn_word[30:21], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- decoder/insn_decode.sv
`default_nettype none

module insn_decode import frontend_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        stage1_valid,
	input  insn_class_e insn_class,
	input  reg_idx_t    rd,
	input  reg_idx_t    rs1,
	input  reg_idx_t    rs2,
	input  word_t       imm_j,
	input  word_t       held_word,
	output logic        decode_valid,
	output insn_kind_e  insn_kind,
	output reg_idx_t    dec_rd,
	output reg_idx_t    dec_rs1,
	output reg_idx_t    dec_rs2,
	output word_t       dec_imm
);

	logic [2:0] f3;
	logic [6:0] f7;
	insn_kind_e next_kind;
	word_t      next_imm;

	assign f3 = held_word[14:12];
	assign f7 = held_word[31:25];

	always_comb begin
		next_kind = KIND_ILLEGAL;
		case (insn_class)
			CLS_LUI:   next_kind = KIND_LUI;
			CLS_AUIPC: next_kind = KIND_AUIPC;
			CLS_JAL:   next_kind = KIND_JAL;
			CLS_JALR:  next_kind = KIND_JALR;
			CLS_BRANCH: begin
				case (f3)
					F3_BEQ:  next_kind = KIND_BEQ;
					F3_BNE:  next_kind = KIND_BNE;
					F3_BLT:  next_kind = KIND_BLT;
					F3_BGE:  next_kind = KIND_BGE;
					F3_BLTU: next_kind = KIND_BLTU;
					F3_BGEU: next_kind = KIND_BGEU;
					default: next_kind = KIND_ILLEGAL;
				endcase
			end
			CLS_LOAD: begin
				case (f3)
					F3_B:    next_kind = KIND_LB;
					F3_H:    next_kind = KIND_LH;
					F3_W:    next_kind = KIND_LW;
					F3_BU:   next_kind = KIND_LBU;
					F3_HU:   next_kind = KIND_LHU;
					default: next_kind = KIND_ILLEGAL;
				endcase
			end
			CLS_STORE: begin
				case (f3)
					F3_B:    next_kind = KIND_SB;
					F3_H:    next_kind = KIND_SH;
					F3_W:    next_kind = KIND_SW;
					default: next_kind = KIND_ILLEGAL;
				endcase
			end
			CLS_OP_IMM: begin
				case (f3)
					F3_ADD:  next_kind = KIND_ADDI;
					F3_SLT:  next_kind = KIND_SLTI;
					F3_SLTU: next_kind = KIND_SLTIU;
					F3_XOR:  next_kind = KIND_XORI;
					F3_OR:   next_kind = KIND_ORI;
					F3_AND:  next_kind = KIND_ANDI;
					F3_SLL:  next_kind = (f7 == F7_BASE) ? KIND_SLLI : KIND_ILLEGAL;
					F3_SR: begin
						if (f7 == F7_BASE)
							next_kind = KIND_SRLI;
						else if (f7 == F7_ALT)
							next_kind = KIND_SRAI;
					end
				endcase
			end
			CLS_OP: begin
				if (f7 == F7_BASE) begin
					case (f3)
						F3_ADD:  next_kind = KIND_ADD;
						F3_SLL:  next_kind = KIND_SLL;
						F3_SLT:  next_kind = KIND_SLT;
						F3_SLTU: next_kind = KIND_SLTU;
						F3_XOR:  next_kind = KIND_XOR;
						F3_SR:   next_kind = KIND_SRL;
						F3_OR:   next_kind = KIND_OR;
						F3_AND:  next_kind = KIND_AND;
					endcase
				end else if (f7 == F7_ALT) begin
					if (f3 == F3_ADD)
						next_kind = KIND_SUB;
					else if (f3 == F3_SR)
						next_kind = KIND_SRA;
				end
			end
			CLS_SYSTEM: begin
				// Bit 20 alone tells ecall from ebreak
				if (held_word[31:21] == '0 && held_word[19:7] == '0)
					next_kind = KIND_ECALL_EBREAK;
			end
			default: next_kind = KIND_ILLEGAL;
		endcase
	end

	always_comb begin
		next_imm = '0;
		if (next_kind != KIND_ILLEGAL) begin
			case (insn_class)
				CLS_LUI, CLS_AUIPC: next_imm = {held_word[31:12], 12'b0};
				CLS_JAL: next_imm = imm_j;
				CLS_JALR, CLS_LOAD, CLS_OP_IMM, CLS_SYSTEM:
					next_imm = {{20{held_word[31]}}, held_word[31:20]};
				CLS_STORE: next_imm = {{20{held_word[31]}}, held_word[31:25], held_word[11:7]};
				CLS_BRANCH: next_imm = {{20{held_word[31]}}, held_word[7], held_word[30:25],
						held_word[11:8], 1'b0};
				default: next_imm = '0; // R-type
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			decode_valid <= 1'b0;
			insn_kind    <= KIND_ILLEGAL;
		end else begin
			decode_valid <= stage1_valid;
			if (stage1_valid)
				insn_kind <= next_kind;
		end
	end

	always_ff @(posedge clk) begin
		if (stage1_valid) begin
			dec_rd  <= rd;
			dec_rs1 <= rs1;
			dec_rs2 <= rs2;
			dec_imm <= next_imm;
		end
	end

	// Stage 1 lets only 32-bit encodings through as a known class
	a_legal_is_32bit: assert property (@(posedge clk) disable iff (!resetn)
			stage1_valid && next_kind != KIND_ILLEGAL |-> held_word[1:0] == 2'b11);

endmodule

`default_nettype wire

//--- source/fetch_decode_top.sv
`default_nettype none

module fetch_decode_top import frontend_pkg::*; #(
	parameter bit LATCHED_MEM_RDATA = 1'b0
) (
	input  logic       clk,
	input  logic       resetn,
	input  logic       mem_do_prefetch,
	input  logic       mem_do_rinst,
	input  logic       mem_do_rdata,
	input  logic       mem_do_wdata,
	input  word_t      fetch_pc,
	input  word_t      data_addr,
	output logic       mem_valid,
	output logic       mem_instr,
	input  logic       mem_ready,
	output word_t      mem_addr,
	input  word_t      mem_rdata,
	output logic       mem_la_read,
	output logic       mem_la_write,
	output word_t      mem_la_addr,
	output logic       mem_done,
	output logic       decode_valid,
	output insn_kind_e insn_kind,
	output reg_idx_t   dec_rd,
	output reg_idx_t   dec_rs1,
	output reg_idx_t   dec_rs2,
	output word_t      dec_imm
);

	logic        rinst_done;
	word_t       insn_word;
	logic        stage1_valid;
	insn_class_e insn_class;
	reg_idx_t    rd;
	reg_idx_t    rs1;
	reg_idx_t    rs2;
	word_t       imm_j;
	word_t       held_word;

	mem_port #(
		.LATCHED_MEM_RDATA(LATCHED_MEM_RDATA)
	) mem_port_inst (
		.clk(clk), .resetn(resetn),
		.mem_do_prefetch(mem_do_prefetch), .mem_do_rinst(mem_do_rinst),
		.mem_do_rdata(mem_do_rdata), .mem_do_wdata(mem_do_wdata),
		.fetch_pc(fetch_pc), .data_addr(data_addr),
		.mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
		.mem_addr(mem_addr), .mem_rdata(mem_rdata),
		.mem_la_read(mem_la_read), .mem_la_write(mem_la_write), .mem_la_addr(mem_la_addr),
		.mem_done(mem_done), .rinst_done(rinst_done), .insn_word(insn_word)
	);

	opcode_predecode opcode_predecode_inst (
		.clk(clk), .resetn(resetn),
		.rinst_done(rinst_done), .insn_word(insn_word),
		.stage1_valid(stage1_valid), .insn_class(insn_class),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm_j(imm_j), .held_word(held_word)
	);

	insn_decode insn_decode_inst (
		.clk(clk), .resetn(resetn),
		.stage1_valid(stage1_valid), .insn_class(insn_class),
		.rd(rd), .rs1(rs1), .rs2(rs2), .imm_j(imm_j), .held_word(held_word),
		.decode_valid(decode_valid), .insn_kind(insn_kind),
		.dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_imm(dec_imm)
	);

endmodule

`default_nettype wire

//--- testbench/tb_memory.sv
`default_nettype none

module tb_memory import frontend_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        mem_valid,
	input  logic        mem_instr,
	input  word_t       mem_addr,
	output logic        mem_ready,
	output word_t       mem_rdata,
	output int unsigned xfer_count,
	output word_t       last_addr,
	output logic        last_instr
);

	word_t       mem_array [0:255];
	int unsigned stall_left;
	logic        stalling;

	initial begin
		for (int i = 0; i < 256; i++)
			mem_array[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h3c};
		mem_ready  = 1'b0;
		mem_rdata  = '0;
		xfer_count = 0;
		last_addr  = '0;
		last_instr = 1'b0;
		stalling   = 1'b0;
		stall_left = 0;
	end

	// Both high here means the transfer lands on the coming edge
	always @(negedge clk) begin
		if (resetn && mem_valid && mem_ready) begin
			xfer_count++;
			last_addr  = mem_addr;
			last_instr = mem_instr;
		end
	end

	always @(posedge clk) begin
		#1;
		if (!resetn || mem_ready) begin
			mem_ready = 1'b0;
			mem_rdata = '0;
		end else if (mem_valid) begin
			if (!stalling) begin
				stall_left = $urandom_range(3, 0);
				stalling   = 1'b1;
			end
			if (stall_left == 0) begin
				mem_ready = 1'b1;
				mem_rdata = mem_array[mem_addr[9:2]];
				stalling  = 1'b0;
			end else begin
				stall_left--;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_fetch_decode.sv
`default_nettype none

module tb_fetch_decode import frontend_pkg::*; ();

	localparam int REQ_FETCH  = 0;
	localparam int REQ_READ   = 1;
	localparam int REQ_WRITE  = 2;
	localparam int N_ADDR     = 50;
	localparam int N_LEGAL    = 200;
	localparam int N_RAW      = 100;
	localparam int N_DATA     = 60;
	localparam int N_PREFETCH = 40;
	localparam int TIMEOUT_CYCLES = 20 * (N_ADDR + N_LEGAL + N_RAW + N_DATA + N_PREFETCH);

	logic        clk;
	logic        resetn;
	logic        mem_do_prefetch;
	logic        mem_do_rinst;
	logic        mem_do_rdata;
	logic        mem_do_wdata;
	word_t       fetch_pc;
	word_t       data_addr;
	logic        mem_valid;
	logic        mem_instr;
	logic        mem_ready;
	word_t       mem_addr;
	word_t       mem_rdata;
	logic        mem_la_read;
	logic        mem_la_write;
	word_t       mem_la_addr;
	logic        mem_done;
	logic        decode_valid;
	insn_kind_e  insn_kind;
	reg_idx_t    dec_rd;
	reg_idx_t    dec_rs1;
	reg_idx_t    dec_rs2;
	word_t       dec_imm;
	int unsigned xfer_count;
	word_t       last_addr;
	logic        last_instr;

	int          checks;
	int          errors;
	int          test_checks;
	int          test_errors;
	int unsigned done_count;
	int unsigned cycle_count;
	logic        stall_seen;
	word_t       stall_addr;
	logic        stall_instr;
	int          seed_value;
	word_t       addr;
	word_t       word;

	fetch_decode_top #(
		.LATCHED_MEM_RDATA(1'b0)
	) fetch_decode_top_inst (
		.clk(clk), .resetn(resetn),
		.mem_do_prefetch(mem_do_prefetch), .mem_do_rinst(mem_do_rinst),
		.mem_do_rdata(mem_do_rdata), .mem_do_wdata(mem_do_wdata),
		.fetch_pc(fetch_pc), .data_addr(data_addr),
		.mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
		.mem_addr(mem_addr), .mem_rdata(mem_rdata),
		.mem_la_read(mem_la_read), .mem_la_write(mem_la_write), .mem_la_addr(mem_la_addr),
		.mem_done(mem_done), .decode_valid(decode_valid), .insn_kind(insn_kind),
		.dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_imm(dec_imm)
	);

	tb_memory tb_memory_inst (
		.clk(clk), .resetn(resetn),
		.mem_valid(mem_valid), .mem_instr(mem_instr), .mem_addr(mem_addr),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.xfer_count(xfer_count), .last_addr(last_addr), .last_instr(last_instr)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	// Bus must hold still across a stall
	always @(negedge clk) begin
		if (stall_seen) begin
			checks++;
			if (mem_valid !== 1'b1 || mem_addr !== stall_addr || mem_instr !== stall_instr)
				report_mismatch("bus signals changed during a mem_ready stall");
		end
		stall_seen  = resetn && mem_valid && !mem_ready;
		stall_addr  = mem_addr;
		stall_instr = mem_instr;
		if (resetn && mem_done)
			done_count++;
	end

	task automatic report_mismatch(input string msg);
		begin
			$display("mismatch at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		begin
			$display("test %s finished with %0d checks and %0d errors", name,
					checks - test_checks, errors - test_errors);
			test_checks = checks;
			test_errors = errors;
		end
	endtask

	// Reference RV32I decoder, straight from the encoding tables
	function automatic insn_kind_e ref_kind(input word_t w);
		logic [2:0] f3;
		logic [6:0] f7;
		insn_kind_e k;
		begin
			f3 = w[14:12];
			f7 = w[31:25];
			k  = KIND_ILLEGAL;
			case (w[6:0])
				7'b0110111: k = KIND_LUI;
				7'b0010111: k = KIND_AUIPC;
				7'b1101111: k = KIND_JAL;
				7'b1100111: if (f3 == 3'd0) k = KIND_JALR;
				7'b1100011: begin
					case (f3)
						3'd0: k = KIND_BEQ;
						3'd1: k = KIND_BNE;
						3'd4: k = KIND_BLT;
						3'd5: k = KIND_BGE;
						3'd6: k = KIND_BLTU;
						3'd7: k = KIND_BGEU;
						default: k = KIND_ILLEGAL;
					endcase
				end
				7'b0000011: begin
					case (f3)
						3'd0: k = KIND_LB;
						3'd1: k = KIND_LH;
						3'd2: k = KIND_LW;
						3'd4: k = KIND_LBU;
						3'd5: k = KIND_LHU;
						default: k = KIND_ILLEGAL;
					endcase
				end
				7'b0100011: begin
					case (f3)
						3'd0: k = KIND_SB;
						3'd1: k = KIND_SH;
						3'd2: k = KIND_SW;
						default: k = KIND_ILLEGAL;
					endcase
				end
				7'b0010011: begin
					case (f3)
						3'd0: k = KIND_ADDI;
						3'd2: k = KIND_SLTI;
						3'd3: k = KIND_SLTIU;
						3'd4: k = KIND_XORI;
						3'd6: k = KIND_ORI;
						3'd7: k = KIND_ANDI;
						3'd1: if (f7 == 7'h00) k = KIND_SLLI;
						3'd5: begin
							if (f7 == 7'h00)
								k = KIND_SRLI;
							else if (f7 == 7'h20)
								k = KIND_SRAI;
						end
					endcase
				end
				7'b0110011: begin
					if (f7 == 7'h00) begin
						case (f3)
							3'd0: k = KIND_ADD;
							3'd1: k = KIND_SLL;
							3'd2: k = KIND_SLT;
							3'd3: k = KIND_SLTU;
							3'd4: k = KIND_XOR;
							3'd5: k = KIND_SRL;
							3'd6: k = KIND_OR;
							3'd7: k = KIND_AND;
						endcase
					end else if (f7 == 7'h20 && f3 == 3'd0) begin
						k = KIND_SUB;
					end else if (f7 == 7'h20 && f3 == 3'd5) begin
						k = KIND_SRA;
					end
				end
				7'b1110011: if (w == 32'h00000073 || w == 32'h00100073) k = KIND_ECALL_EBREAK;
				default: k = KIND_ILLEGAL;
			endcase
			return k;
		end
	endfunction

	function automatic word_t ref_imm(input word_t w, input insn_kind_e k);
		begin
			if (k == KIND_ILLEGAL)
				return '0;
			case (w[6:0])
				7'b0110111, 7'b0010111: return {w[31:12], 12'b0};
				7'b1101111: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011:
					return {{20{w[31]}}, w[31:20]};
				7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
				7'b1100011: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				default: return '0;
			endcase
		end
	endfunction

	function automatic word_t make_legal(input int unsigned sel, input word_t r);
		word_t w;
		begin
			w = r;
			case (sel % 10)
				0: w[6:0] = 7'b0110111;
				1: w[6:0] = 7'b0010111;
				2: w[6:0] = 7'b1101111;
				3: begin
					w[6:0]   = 7'b1100111;
					w[14:12] = 3'b000;
				end
				4: begin
					w[6:0] = 7'b1100011;
					if (w[14:13] == 2'b01)
						w[14] = 1'b1; // No branch at funct3 2 or 3
				end
				5: begin
					w[6:0] = 7'b0000011;
					if (w[14:12] == 3'b011 || w[14:13] == 2'b11)
						w[14:12] = 3'b010;
				end
				6: begin
					w[6:0] = 7'b0100011;
					w[14]  = 1'b0;
					if (w[13:12] == 2'b11)
						w[13:12] = 2'b10;
				end
				7: begin
					w[6:0] = 7'b0010011;
					if (w[14:12] == 3'b001)
						w[31:25] = 7'h00;
					else if (w[14:12] == 3'b101)
						w[31:25] = {1'b0, w[30], 5'b0};
				end
				8: begin
					w[6:0] = 7'b0110011;
					if (w[14:12] == 3'b000 || w[14:12] == 3'b101)
						w[31:25] = {1'b0, w[30], 5'b0};
					else
						w[31:25] = 7'h00;
				end
				default: w = r[0] ? 32'h00100073 : 32'h00000073;
			endcase
			return w;
		end
	endfunction

	function automatic word_t make_raw(input int unsigned sel, input word_t r);
		word_t w;
		begin
			w = r;
			if (sel % 3 == 1) begin
				w = make_legal(sel / 3, r);
				w[1:0] = (r[1:0] == 2'b11) ? 2'b00 : r[1:0]; // Not a 32-bit encoding
			end else if (sel % 3 == 2) begin
				w[6:0]   = 7'b0110011;
				w[31:25] = r[31:25] | 7'h01; // Never base or alt funct7
			end
			return w;
		end
	endfunction

	// Runs from the edge after mem_done through the decode slot
	task automatic check_completion(input bit is_fetch, input word_t want_word,
			input word_t want_addr, input int unsigned xfers_before,
			input int unsigned dones_before);
		insn_kind_e want_kind;
		word_t      want_imm;
		begin
			want_kind = ref_kind(want_word);
			want_imm  = ref_imm(want_word, want_kind);
			checks++;
			if (xfer_count != xfers_before + 1 || last_addr !== want_addr ||
					last_instr !== is_fetch)
				report_mismatch($sformatf("transfers %0d addr %h instr %b, expected one at %h",
						xfer_count - xfers_before, last_addr, last_instr, want_addr));
			checks++;
			if (done_count != dones_before + 1)
				report_mismatch($sformatf("mem_done seen %0d times for one request",
						done_count - dones_before));
			@(negedge clk);
			checks++;
			if (decode_valid !== 1'b0)
				report_mismatch("decode_valid one cycle after mem_done");
			@(negedge clk);
			checks++;
			if (decode_valid !== is_fetch)
				report_mismatch($sformatf("decode_valid %b two cycles after mem_done",
						decode_valid));
			if (is_fetch) begin
				checks++;
				if (insn_kind !== want_kind || dec_rd !== want_word[11:7] ||
						dec_rs1 !== want_word[19:15] || dec_rs2 !== want_word[24:20] ||
						dec_imm !== want_imm)
					report_mismatch($sformatf(
							"word %h kind %0d/%0d rd %0d rs1 %0d rs2 %0d imm %h/%h",
							want_word, insn_kind, want_kind, dec_rd, dec_rs1, dec_rs2,
							dec_imm, want_imm));
			end
		end
	endtask

	task automatic run_request(input int kind, input word_t req_addr, input word_t want_word);
		int unsigned xfers_before;
		int unsigned dones_before;
		word_t       want_addr;
		begin
			xfers_before = xfer_count;
			dones_before = done_count;
			want_addr    = {req_addr[31:2], 2'b00};
			@(posedge clk);
			#1;
			// The unused address differs so a wrong address source shows up
			fetch_pc     = (kind == REQ_FETCH) ? req_addr : ~req_addr;
			data_addr    = (kind == REQ_FETCH) ? ~req_addr : req_addr;
			mem_do_rinst = (kind == REQ_FETCH);
			mem_do_rdata = (kind == REQ_READ);
			mem_do_wdata = (kind == REQ_WRITE);
			@(negedge clk);
			checks++;
			if (mem_valid !== 1'b0 || mem_la_read !== (kind != REQ_WRITE) ||
					mem_la_write !== (kind == REQ_WRITE) || mem_la_addr !== want_addr)
				report_mismatch($sformatf("look-ahead la_read %b la_write %b la_addr %h for %h",
						mem_la_read, mem_la_write, mem_la_addr, req_addr));
			@(negedge clk);
			checks++;
			if (mem_valid !== 1'b1)
				report_mismatch("mem_valid did not follow the look-ahead cycle");
			while (mem_done !== 1'b1)
				@(negedge clk);
			checks++;
			if (mem_addr !== want_addr || mem_instr !== (kind == REQ_FETCH))
				report_mismatch($sformatf("transfer addr %h instr %b, expected %h",
						mem_addr, mem_instr, want_addr));
			@(posedge clk);
			#1;
			mem_do_rinst = 1'b0;
			mem_do_rdata = 1'b0;
			mem_do_wdata = 1'b0;
			check_completion(kind == REQ_FETCH, want_word, want_addr, xfers_before, dones_before);
		end
	endtask

	task automatic run_prefetch(input word_t req_addr, input word_t want_word);
		int unsigned xfers_before;
		int unsigned dones_before;
		word_t       want_addr;
		begin
			want_addr = {req_addr[31:2], 2'b00};
			tb_memory_inst.mem_array[req_addr[9:2]] = want_word;
			xfers_before = xfer_count;
			dones_before = done_count;
			@(posedge clk);
			#1;
			fetch_pc        = req_addr;
			data_addr       = ~req_addr;
			mem_do_prefetch = 1'b1;
			@(negedge clk);
			checks++;
			if (mem_la_read !== 1'b1 || mem_la_addr !== want_addr)
				report_mismatch($sformatf("prefetch look-ahead la_read %b la_addr %h",
						mem_la_read, mem_la_addr));
			@(negedge clk);
			while (!(mem_valid === 1'b1 && mem_ready === 1'b1))
				@(negedge clk);
			checks++;
			if (mem_done !== 1'b0 || mem_instr !== 1'b1 || mem_addr !== want_addr)
				report_mismatch($sformatf("prefetch transfer done %b instr %b addr %h",
						mem_done, mem_instr, mem_addr));
			@(posedge clk);
			#1;
			tb_memory_inst.mem_array[req_addr[9:2]] = ~want_word; // Held copy must win
			mem_do_rinst = 1'b1;
			@(negedge clk);
			checks++;
			if (mem_done !== 1'b1 || mem_valid !== 1'b0)
				report_mismatch("fetch after prefetch did not complete from the held word");
			@(posedge clk);
			#1;
			mem_do_prefetch = 1'b0;
			mem_do_rinst    = 1'b0;
			check_completion(1'b1, want_word, want_addr, xfers_before, dones_before);
		end
	endtask

	initial begin
		seed_value      = 32'h8a38;
		void'($urandom(seed_value));
		clk             = 1'b0;
		resetn          = 1'b0;
		mem_do_prefetch = 1'b0;
		mem_do_rinst    = 1'b0;
		mem_do_rdata    = 1'b0;
		mem_do_wdata    = 1'b0;
		fetch_pc        = '0;
		data_addr       = '0;
		checks          = 0;
		errors          = 0;
		test_checks     = 0;
		test_errors     = 0;
		done_count      = 0;
		cycle_count     = 0;
		stall_seen      = 1'b0;

		repeat (3) @(posedge clk);
		@(negedge clk);
		checks++;
		if (mem_valid !== 1'b0 || mem_la_read !== 1'b0 || mem_la_write !== 1'b0 ||
				mem_done !== 1'b0 || decode_valid !== 1'b0 || insn_kind !== KIND_ILLEGAL)
			report_mismatch("outputs not idle during reset");
		@(posedge clk);
		#1;
		resetn = 1'b1;
		end_test("reset");

		for (int n = 0; n < N_ADDR; n++) begin
			addr = $urandom;
			run_request(REQ_FETCH, addr, tb_memory_inst.mem_array[addr[9:2]]);
		end
		end_test("fetch addressing");

		for (int n = 0; n < N_LEGAL; n++) begin
			addr = $urandom;
			word = make_legal($urandom, $urandom);
			tb_memory_inst.mem_array[addr[9:2]] = word;
			run_request(REQ_FETCH, addr, word);
		end
		end_test("legal decode");

		for (int n = 0; n < N_RAW; n++) begin
			addr = $urandom;
			word = make_raw($urandom, $urandom);
			tb_memory_inst.mem_array[addr[9:2]] = word;
			run_request(REQ_FETCH, addr, word);
		end
		end_test("raw decode");

		for (int n = 0; n < N_DATA; n++) begin
			addr = $urandom;
			run_request((n % 2 == 0) ? REQ_READ : REQ_WRITE, addr, '0);
		end
		end_test("data transfers");

		for (int n = 0; n < N_PREFETCH; n++) begin
			addr = $urandom;
			run_prefetch(addr, make_legal($urandom, $urandom));
		end
		end_test("prefetch then fetch");

		$display("total %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
common/frontend_pkg.sv
source/mem_port.sv
decoder/opcode_predecode.sv
decoder/insn_decode.sv
source/fetch_decode_top.sv
testbench/tb_memory.sv
testbench/tb_fetch_decode.sv
